// File: compile.f
+incdir+src
src/tpl_dac_pkg.sv
src/tpl_dac_regs.sv
src/tpl_dac_unpack.sv
src/tpl_dac_source.sv
src/tpl_dac_framer.sv
src/tpl_dac.sv
sim/tb_tpl_dac.sv

// File: Makefile
# Verilator build for the transport layer testbench

TOP = tb_tpl_dac

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f compile.f --top-module $(TOP) -Mdir obj_dir

run: compile
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim/tb_tpl_dac.sv
// testbench for the jesd204 dac transport layer with reference model, compare process and watchdog

`timescale 1ns/1ps
`default_nettype none

`include "tpl_dac_params.svh"

module tb_tpl_dac;

  localparam int CLK_PERIOD  = 40;
  localparam int PASS_BEATS  = 64;
  localparam int INT_BEATS   = 24;
  localparam int HOLD_BEATS  = 2;
  localparam int TOTAL_BEATS = 2 * PASS_BEATS + 2 * INT_BEATS + HOLD_BEATS;
  // extra cycles cover reset and register traffic
  localparam int SETUP_CYCLES = 200;

  logic                           link_clk;
  logic                           rst_n;
  logic                           dma_valid;
  wire                            dma_ready;
  logic [`TPL_DMA_WIDTH-1:0]      dma_data;
  wire                            link_valid;
  logic                           link_ready;
  wire [`TPL_LINK_WIDTH-1:0]      link_data;
  wire [`TPL_NUM_CHANNELS-1:0]    enable;
  logic                           cfg_wr;
  tpl_dac_pkg::reg_addr_t         cfg_addr;
  logic [31:0]                    cfg_wdata;
  wire [31:0]                     cfg_rdata;

  // reference model state
  logic                           model_pad;
  tpl_dac_pkg::src_sel_t          model_sel [`TPL_NUM_CHANNELS];
  logic [15:0]                    model_pattern [`TPL_NUM_CHANNELS];
  logic [15:0]                    model_incr [`TPL_NUM_CHANNELS];
  logic [15:0]                    model_acc [`TPL_NUM_CHANNELS];

  logic [`TPL_LINK_WIDTH-1:0]     expected_q [$];
  logic [31:0]                    lcg_state;
  int                             rx_count;
  int                             rx_base;
  // 0 ready high, 1 random, 2 held low
  int                             ready_mode;

  tpl_dac tpl_dac_inst (
    .link_clk   (link_clk),
    .rst_n      (rst_n),
    .dma_valid  (dma_valid),
    .dma_ready  (dma_ready),
    .dma_data   (dma_data),
    .link_valid (link_valid),
    .link_ready (link_ready),
    .link_data  (link_data),
    .enable     (enable),
    .cfg_wr     (cfg_wr),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .cfg_rdata  (cfg_rdata)
  );

  initial begin
    link_clk = 1'b0;
    forever #(CLK_PERIOD / 2) link_clk = ~link_clk;
  end

  // ************************************************************
  // helpers
  // ************************************************************

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  // expected link word, advances the model ramps like one emitted beat
  function automatic logic [63:0] expected_word(input logic [95:0] dma);
    logic [15:0] smp;
    logic [23:0] slot;
    logic [63:0] word;
    word = '0;
    for (int c = 0; c < 2; c++) begin
      for (int s = 0; s < 2; s++) begin
        slot = dma[(c * 2 + s) * 24 +: 24];
        case (model_sel[c])
          tpl_dac_pkg::SRC_DMA:     smp = model_pad ? slot[23:8] : slot[15:0];
          tpl_dac_pkg::SRC_PATTERN: smp = model_pattern[c];
          tpl_dac_pkg::SRC_RAMP:    smp = (s == 0) ? model_acc[c] : model_acc[c] + model_incr[c];
          default:                  smp = 16'h0000;
        endcase
        // high octet first on the lane
        word[c * 32 + s * 16 +: 8]     = smp[15:8];
        word[c * 32 + s * 16 + 8 +: 8] = smp[7:0];
      end
      if (model_sel[c] == tpl_dac_pkg::SRC_RAMP) begin
        model_acc[c] = model_acc[c] + model_incr[c] + model_incr[c];
      end
    end
    return word;
  endfunction

  function automatic logic dma_mode();
    return (model_sel[0] == tpl_dac_pkg::SRC_DMA) && (model_sel[1] == tpl_dac_pkg::SRC_DMA);
  endfunction

  // one cycle, inputs change 2 ns after the edge
  task automatic tick();
    logic [31:0] r;
    @(posedge link_clk);
    #2;
    r = lcg_next();
    case (ready_mode)
      1:       link_ready = (r[31:30] != 2'b00);
      2:       link_ready = 1'b0;
      default: link_ready = 1'b1;
    endcase
  endtask

  task automatic write_reg(input tpl_dac_pkg::reg_addr_t addr, input logic [31:0] data);
    cfg_wr    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    tick();
    cfg_wr = 1'b0;
    case (addr)
      tpl_dac_pkg::REG_CTRL:       model_pad = data[1];
      tpl_dac_pkg::REG_SRC_SEL: begin
        model_sel[0] = tpl_dac_pkg::src_sel_t'(data[1:0]);
        model_sel[1] = tpl_dac_pkg::src_sel_t'(data[3:2]);
      end
      tpl_dac_pkg::REG_PATTERN0:   model_pattern[0] = data[15:0];
      tpl_dac_pkg::REG_PATTERN1:   model_pattern[1] = data[15:0];
      tpl_dac_pkg::REG_RAMP_INCR0: model_incr[0] = data[15:0];
      tpl_dac_pkg::REG_RAMP_INCR1: model_incr[1] = data[15:0];
      default: ;
    endcase
  endtask

  task automatic read_check(input tpl_dac_pkg::reg_addr_t addr, input logic [31:0] exp);
    cfg_addr = addr;
    #1;
    check_value({32'd0, cfg_rdata}, {32'd0, exp}, "cfg_rdata");
  endtask

  task automatic send_beats(input int n);
    logic accepted;
    for (int i = 0; i < n; i++) begin
      dma_valid = 1'b1;
      dma_data  = {lcg_next(), lcg_next(), lcg_next()};
      accepted  = 1'b0;
      while (!accepted) begin
        #1;
        accepted = dma_ready;
        tick();
      end
    end
    dma_valid = 1'b0;
  endtask

  task automatic wait_rx(input int target);
    while (rx_count < target) begin
      tick();
    end
  endtask

  // park the pipeline full, drop run, then drain
  task automatic stop_internal();
    ready_mode = 2;
    repeat (4) tick();
    write_reg(tpl_dac_pkg::REG_CTRL, {30'd0, model_pad, 1'b0});
    ready_mode = 0;
    repeat (6) tick();
    #1;
    check_value({63'd0, link_valid}, 64'd0, "link_valid after stop");
  endtask

  // ************************************************************
  // compare process
  // ************************************************************

  always @(posedge link_clk) begin : compare_proc
    logic [63:0] exp;
    if (rst_n) begin
      if (dma_valid && dma_ready && dma_mode()) begin
        expected_q.push_back(expected_word(dma_data));
      end
      if (link_valid && link_ready) begin
        if (dma_mode() && expected_q.size() == 0) begin
          $display("link beat arrived with no DMA beat pending at %0t ns", $time);
          $display("TEST FAILED");
          $fatal(1, "unexpected beat");
        end else begin
          if (dma_mode()) begin
            exp = expected_q.pop_front();
          end else begin
            exp = expected_word('0);
          end
          check_value(link_data, exp, "link_data");
          rx_count++;
        end
      end
    end
  end

  initial begin : watchdog
    #((TOTAL_BEATS * CLK_PERIOD * 4) + SETUP_CYCLES * CLK_PERIOD);
    $display("simulation timed out waiting for link beats");
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

  // ************************************************************
  // stimulus
  // ************************************************************

  initial begin
    rst_n       = 1'b0;
    dma_valid   = 1'b0;
    dma_data    = '0;
    link_ready  = 1'b1;
    cfg_wr      = 1'b0;
    cfg_addr    = tpl_dac_pkg::REG_CTRL;
    cfg_wdata   = '0;
    lcg_state   = 32'd60;
    rx_count    = 0;
    rx_base     = 0;
    ready_mode  = 0;
    model_pad   = 1'b0;
    for (int c = 0; c < 2; c++) begin
      model_sel[c]     = tpl_dac_pkg::SRC_DMA;
      model_pattern[c] = '0;
      model_incr[c]    = '0;
      model_acc[c]     = '0;
    end
    repeat (16) tick();
    rst_n = 1'b1;
    tick();

    // readback and enable decode
    write_reg(tpl_dac_pkg::REG_PATTERN0, 32'h1234_abcd);
    write_reg(tpl_dac_pkg::REG_PATTERN1, 32'h0000_5a5a);
    write_reg(tpl_dac_pkg::REG_RAMP_INCR0, 32'h0000_0123);
    write_reg(tpl_dac_pkg::REG_RAMP_INCR1, 32'h0000_fff7);
    read_check(tpl_dac_pkg::REG_PATTERN0, 32'h0000_abcd);
    read_check(tpl_dac_pkg::REG_PATTERN1, 32'h0000_5a5a);
    read_check(tpl_dac_pkg::REG_RAMP_INCR0, 32'h0000_0123);
    read_check(tpl_dac_pkg::REG_RAMP_INCR1, 32'h0000_fff7);
    read_check(tpl_dac_pkg::reg_addr_t'(4'd9), 32'd0);
    write_reg(tpl_dac_pkg::REG_CTRL, 32'h1);
    read_check(tpl_dac_pkg::REG_CTRL, 32'h1);
    check_value({62'd0, enable}, 64'd3, "enable");
    write_reg(tpl_dac_pkg::REG_SRC_SEL, 32'h4);
    read_check(tpl_dac_pkg::REG_SRC_SEL, 32'h4);
    check_value({62'd0, enable}, 64'd1, "enable");
    write_reg(tpl_dac_pkg::REG_CTRL, 32'h0);
    #1;
    check_value({62'd0, enable}, 64'd0, "enable");
    write_reg(tpl_dac_pkg::REG_SRC_SEL, 32'h0);

    // dma passthrough, lsb then msb packing
    write_reg(tpl_dac_pkg::REG_CTRL, 32'h1);
    ready_mode = 1;
    send_beats(PASS_BEATS);
    wait_rx(PASS_BEATS);
    write_reg(tpl_dac_pkg::REG_CTRL, 32'h3);
    send_beats(PASS_BEATS);
    wait_rx(2 * PASS_BEATS);
    ready_mode = 0;
    write_reg(tpl_dac_pkg::REG_CTRL, 32'h0);

    // pattern on channel 0, zero on channel 1
    write_reg(tpl_dac_pkg::REG_SRC_SEL, 32'hd);
    write_reg(tpl_dac_pkg::REG_CTRL, 32'h1);
    ready_mode = 1;
    wait_rx(rx_count + INT_BEATS);
    stop_internal();

    // ramps, one increment wraps around
    write_reg(tpl_dac_pkg::REG_SRC_SEL, 32'ha);
    model_acc[0] = '0;
    model_acc[1] = '0;
    write_reg(tpl_dac_pkg::REG_CTRL, 32'h1);
    ready_mode = 1;
    wait_rx(rx_count + INT_BEATS);
    stop_internal();

    // held beats while run is low
    rx_base = rx_count;
    write_reg(tpl_dac_pkg::REG_SRC_SEL, 32'h0);
    write_reg(tpl_dac_pkg::REG_CTRL, 32'h2);
    send_beats(1);
    dma_valid = 1'b1;
    dma_data  = {lcg_next(), lcg_next(), lcg_next()};
    repeat (6) begin
      tick();
      #1;
      check_value({62'd0, link_valid, dma_ready}, 64'd0, "valid/ready while stopped");
    end
    write_reg(tpl_dac_pkg::REG_CTRL, 32'h3);
    #1;
    while (!dma_ready) begin
      tick();
      #1;
    end
    tick();
    dma_valid = 1'b0;
    wait_rx(rx_base + HOLD_BEATS);
    repeat (4) tick();

    if (expected_q.size() == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("beats left over at end of run");
      $display("TEST FAILED");
      $fatal(1, "end of run");
    end
  end

endmodule

`default_nettype wire

// File: src/tpl_dac.sv
// transport layer top with register file, unpack, source and framer stages

`timescale 1ns/1ps
`default_nettype none

`include "tpl_dac_params.svh"

module tpl_dac (
  input  wire                          link_clk,
  input  wire                          rst_n,
  input  wire                          dma_valid,
  output wire                          dma_ready,
  input  wire tpl_dac_pkg::dma_beat_t  dma_data,
  output wire                          link_valid,
  input  wire                          link_ready,
  output wire [`TPL_LINK_WIDTH-1:0]    link_data,
  output wire [`TPL_NUM_CHANNELS-1:0]  enable,
  input  wire                          cfg_wr,
  input  wire tpl_dac_pkg::reg_addr_t  cfg_addr,
  input  wire [31:0]                   cfg_wdata,
  output wire [31:0]                   cfg_rdata
);

  wire                        run;
  wire                        pad_msb;
  wire                        ramp_clear;
  wire tpl_dac_pkg::src_sel_t src_sel [`TPL_NUM_CHANNELS];
  wire tpl_dac_pkg::sample_t  pattern [`TPL_NUM_CHANNELS];
  wire tpl_dac_pkg::sample_t  ramp_incr [`TPL_NUM_CHANNELS];

  // stage to stage streams
  wire                        unpack_valid;
  wire                        unpack_ready;
  wire tpl_dac_pkg::beat_t    unpack_data;
  wire                        source_valid;
  wire                        source_ready;
  wire tpl_dac_pkg::beat_t    source_data;

  tpl_dac_regs tpl_dac_regs_inst (
    .link_clk   (link_clk),
    .rst_n      (rst_n),
    .cfg_wr     (cfg_wr),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .cfg_rdata  (cfg_rdata),
    .run        (run),
    .pad_msb    (pad_msb),
    .src_sel    (src_sel),
    .pattern    (pattern),
    .ramp_incr  (ramp_incr),
    .ramp_clear (ramp_clear),
    .enable     (enable)
  );

  // ************************************************************
  // three stage pipeline, one register each
  // ************************************************************

  tpl_dac_unpack tpl_dac_unpack_inst (
    .link_clk  (link_clk),
    .rst_n     (rst_n),
    .pad_msb   (pad_msb),
    .in_valid  (dma_valid),
    .in_data   (dma_data),
    .in_ready  (dma_ready),
    .out_valid (unpack_valid),
    .out_data  (unpack_data),
    .out_ready (unpack_ready)
  );

  tpl_dac_source tpl_dac_source_inst (
    .link_clk   (link_clk),
    .rst_n      (rst_n),
    .run        (run),
    .src_sel    (src_sel),
    .pattern    (pattern),
    .ramp_incr  (ramp_incr),
    .ramp_clear (ramp_clear),
    .in_valid   (unpack_valid),
    .in_data    (unpack_data),
    .in_ready   (unpack_ready),
    .out_valid  (source_valid),
    .out_data   (source_data),
    .out_ready  (source_ready)
  );

  tpl_dac_framer tpl_dac_framer_inst (
    .link_clk  (link_clk),
    .rst_n     (rst_n),
    .in_valid  (source_valid),
    .in_data   (source_data),
    .in_ready  (source_ready),
    .out_valid (link_valid),
    .out_data  (link_data),
    .out_ready (link_ready)
  );

endmodule

`default_nettype wire

// File: src/tpl_dac_framer.sv
// framer stage mapping channel samples onto lane octets

`timescale 1ns/1ps
`default_nettype none

`include "tpl_dac_params.svh"

module tpl_dac_framer (
  input  wire                        link_clk,
  input  wire                        rst_n,
  input  wire                        in_valid,
  input  wire tpl_dac_pkg::beat_t    in_data,
  output logic                       in_ready,
  output logic                       out_valid,
  output logic [`TPL_LINK_WIDTH-1:0] out_data,
  input  wire                        out_ready
);

  localparam int SAMPLE_W = `TPL_BITS_PER_SAMPLE;
  localparam int CH_W     = `TPL_SAMPLES_PER_BEAT * SAMPLE_W;
  localparam int LANE_W   = `TPL_OCTETS_PER_BEAT * 8;

  tpl_dac_pkg::lane_word_t   lane_word [`TPL_NUM_LANES];
  logic [`TPL_LINK_WIDTH-1:0] framed;

  // lane k carries channel k, high octet goes out first
  always_comb begin
    tpl_dac_pkg::sample_t s0;
    tpl_dac_pkg::sample_t s1;
    for (int k = 0; k < `TPL_NUM_LANES; k++) begin
      s0 = in_data[k*CH_W +: SAMPLE_W];
      s1 = in_data[k*CH_W + SAMPLE_W +: SAMPLE_W];
      lane_word[k] = {s1[7:0], s1[15:8], s0[7:0], s0[15:8]};
      framed[k*LANE_W +: LANE_W] = lane_word[k];
    end
  end

  // ************************************************************
  // output register toward the link layer
  // ************************************************************

  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge link_clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge link_clk) begin
    if (in_valid && in_ready) begin
      out_data <= framed;
    end
  end

endmodule

`default_nettype wire

// File: src/tpl_dac_source.sv
// source stage with per-channel source mux, ramp generators and run gating

`timescale 1ns/1ps
`default_nettype none

`include "tpl_dac_params.svh"

module tpl_dac_source (
  input  wire                         link_clk,
  input  wire                         rst_n,
  input  wire                         run,
  input  wire tpl_dac_pkg::src_sel_t  src_sel [`TPL_NUM_CHANNELS],
  input  wire tpl_dac_pkg::sample_t   pattern [`TPL_NUM_CHANNELS],
  input  wire tpl_dac_pkg::sample_t   ramp_incr [`TPL_NUM_CHANNELS],
  input  wire                         ramp_clear,
  input  wire                         in_valid,
  input  wire tpl_dac_pkg::beat_t     in_data,
  output logic                        in_ready,
  output logic                        out_valid,
  output tpl_dac_pkg::beat_t          out_data,
  input  wire                         out_ready
);

  localparam int CH_W = `TPL_SAMPLES_PER_BEAT * `TPL_BITS_PER_SAMPLE;

  logic                 uses_dma;
  logic                 out_free;
  logic                 load;
  tpl_dac_pkg::beat_t   next_data;
  tpl_dac_pkg::sample_t ramp_acc [`TPL_NUM_CHANNELS];

  always_comb begin
    uses_dma = 1'b0;
    for (int c = 0; c < `TPL_NUM_CHANNELS; c++) begin
      if (src_sel[c] == tpl_dac_pkg::SRC_DMA) begin
        uses_dma = 1'b1;
      end
    end
  end

  // internal sources need no input beat
  assign out_free = !out_valid || out_ready;
  assign in_ready = run && uses_dma && out_free;
  assign load     = run && out_free && (!uses_dma || in_valid);

  // ************************************************************
  // per-channel source mux, sample 0 in the low half
  // ************************************************************

  always_comb begin
    for (int c = 0; c < `TPL_NUM_CHANNELS; c++) begin
      case (src_sel[c])
        tpl_dac_pkg::SRC_DMA:     next_data[c*CH_W +: CH_W] = in_data[c*CH_W +: CH_W];
        tpl_dac_pkg::SRC_PATTERN: next_data[c*CH_W +: CH_W] = {pattern[c], pattern[c]};
        tpl_dac_pkg::SRC_RAMP:
          next_data[c*CH_W +: CH_W] = {ramp_acc[c] + ramp_incr[c], ramp_acc[c]};
        default:                  next_data[c*CH_W +: CH_W] = '0;
      endcase
    end
  end

  // ramp steps by two increments for every beat it produces
  always_ff @(posedge link_clk) begin
    if (!rst_n || ramp_clear) begin
      for (int c = 0; c < `TPL_NUM_CHANNELS; c++) begin
        ramp_acc[c] <= '0;
      end
    end else if (load) begin
      for (int c = 0; c < `TPL_NUM_CHANNELS; c++) begin
        if (src_sel[c] == tpl_dac_pkg::SRC_RAMP) begin
          ramp_acc[c] <= ramp_acc[c] + (ramp_incr[c] << 1);
        end
      end
    end
  end

  always_ff @(posedge link_clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge link_clk) begin
    if (load) begin
      out_data <= next_data;
    end
  end

endmodule

`default_nettype wire

// File: src/tpl_dac_unpack.sv
// unpack stage that strips dma padding from each 24-bit slot

`timescale 1ns/1ps
`default_nettype none

`include "tpl_dac_params.svh"

module tpl_dac_unpack (
  input  wire                          link_clk,
  input  wire                          rst_n,
  input  wire                          pad_msb,
  input  wire                          in_valid,
  input  wire tpl_dac_pkg::dma_beat_t  in_data,
  output logic                         in_ready,
  output logic                         out_valid,
  output tpl_dac_pkg::beat_t           out_data,
  input  wire                          out_ready
);

  localparam int NUM_SLOTS = `TPL_NUM_CHANNELS * `TPL_SAMPLES_PER_BEAT;
  localparam int SLOT_W    = `TPL_DMA_BITS_PER_SAMPLE;
  localparam int SAMPLE_W  = `TPL_BITS_PER_SAMPLE;

  tpl_dac_pkg::beat_t stripped;

  // keep 23:8 with msb packing, 15:0 otherwise
  always_comb begin
    for (int i = 0; i < NUM_SLOTS; i++) begin
      if (pad_msb) begin
        stripped[i*SAMPLE_W +: SAMPLE_W] = in_data[(i+1)*SLOT_W-1 -: SAMPLE_W];
      end else begin
        stripped[i*SAMPLE_W +: SAMPLE_W] = in_data[i*SLOT_W +: SAMPLE_W];
      end
    end
  end

  // ************************************************************
  // output register
  // ************************************************************

  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge link_clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge link_clk) begin
    if (in_valid && in_ready) begin
      out_data <= stripped;
    end
  end

endmodule

`default_nettype wire

// File: src/tpl_dac_regs.sv
// configuration register file with write/read port and channel enable decode

`timescale 1ns/1ps
`default_nettype none

`include "tpl_dac_params.svh"

module tpl_dac_regs (
  input  wire                          link_clk,
  input  wire                          rst_n,
  input  wire                          cfg_wr,
  input  wire tpl_dac_pkg::reg_addr_t  cfg_addr,
  input  wire [31:0]                   cfg_wdata,
  output logic [31:0]                  cfg_rdata,
  output logic                         run,
  output logic                         pad_msb,
  output tpl_dac_pkg::src_sel_t        src_sel [`TPL_NUM_CHANNELS],
  output tpl_dac_pkg::sample_t         pattern [`TPL_NUM_CHANNELS],
  output tpl_dac_pkg::sample_t         ramp_incr [`TPL_NUM_CHANNELS],
  output logic                         ramp_clear,
  output logic [`TPL_NUM_CHANNELS-1:0] enable
);

  // ************************************************************
  // register writes
  // ************************************************************

  always_ff @(posedge link_clk) begin
    if (!rst_n) begin
      run     <= 1'b0;
      pad_msb <= 1'b0;
      for (int c = 0; c < `TPL_NUM_CHANNELS; c++) begin
        src_sel[c]   <= tpl_dac_pkg::SRC_DMA;
        pattern[c]   <= '0;
        ramp_incr[c] <= '0;
      end
    end else if (cfg_wr) begin
      case (cfg_addr)
        tpl_dac_pkg::REG_CTRL: begin
          run     <= cfg_wdata[0];
          pad_msb <= cfg_wdata[1];
        end
        tpl_dac_pkg::REG_SRC_SEL: begin
          for (int c = 0; c < `TPL_NUM_CHANNELS; c++) begin
            src_sel[c] <= tpl_dac_pkg::src_sel_t'(cfg_wdata[2*c +: 2]);
          end
        end
        tpl_dac_pkg::REG_PATTERN0:   pattern[0]   <= cfg_wdata[15:0];
        tpl_dac_pkg::REG_PATTERN1:   pattern[1]   <= cfg_wdata[15:0];
        tpl_dac_pkg::REG_RAMP_INCR0: ramp_incr[0] <= cfg_wdata[15:0];
        tpl_dac_pkg::REG_RAMP_INCR1: ramp_incr[1] <= cfg_wdata[15:0];
        default: ;
      endcase
    end
  end

  // clears the ramps on the same edge the new settings land
  assign ramp_clear = cfg_wr && ((cfg_addr == tpl_dac_pkg::REG_CTRL) ||
                                 (cfg_addr == tpl_dac_pkg::REG_RAMP_INCR0) ||
                                 (cfg_addr == tpl_dac_pkg::REG_RAMP_INCR1));

  // dma request per channel
  always_comb begin
    for (int c = 0; c < `TPL_NUM_CHANNELS; c++) begin
      enable[c] = run && (src_sel[c] == tpl_dac_pkg::SRC_DMA);
    end
  end

  // readback, unmapped reads zero
  always_comb begin
    case (cfg_addr)
      tpl_dac_pkg::REG_CTRL:       cfg_rdata = {30'd0, pad_msb, run};
      tpl_dac_pkg::REG_SRC_SEL:    cfg_rdata = {28'd0, src_sel[1], src_sel[0]};
      tpl_dac_pkg::REG_PATTERN0:   cfg_rdata = {16'd0, pattern[0]};
      tpl_dac_pkg::REG_PATTERN1:   cfg_rdata = {16'd0, pattern[1]};
      tpl_dac_pkg::REG_RAMP_INCR0: cfg_rdata = {16'd0, ramp_incr[0]};
      tpl_dac_pkg::REG_RAMP_INCR1: cfg_rdata = {16'd0, ramp_incr[1]};
      default:                     cfg_rdata = 32'd0;
    endcase
  end

endmodule

`default_nettype wire

// File: src/tpl_dac_pkg.sv
// sample, beat, lane word and source select types plus register address map

`default_nettype none

`include "tpl_dac_params.svh"

package tpl_dac_pkg;

  typedef logic [`TPL_BITS_PER_SAMPLE-1:0] sample_t;

  // channel-major, channel c sample s at index c*2+s
  typedef logic [`TPL_NUM_CHANNELS*`TPL_SAMPLES_PER_BEAT*`TPL_BITS_PER_SAMPLE-1:0] beat_t;
  typedef logic [`TPL_DMA_WIDTH-1:0] dma_beat_t;

  // one lane, four octets
  typedef logic [`TPL_OCTETS_PER_BEAT*8-1:0] lane_word_t;

  typedef enum logic [1:0] {
    SRC_DMA     = 2'd0,
    SRC_PATTERN = 2'd1,
    SRC_RAMP    = 2'd2,
    SRC_ZERO    = 2'd3
  } src_sel_t;

  typedef enum logic [3:0] {
    REG_CTRL       = 4'd0,
    REG_SRC_SEL    = 4'd1,
    REG_PATTERN0   = 4'd2,
    REG_PATTERN1   = 4'd3,
    REG_RAMP_INCR0 = 4'd4,
    REG_RAMP_INCR1 = 4'd5
  } reg_addr_t;

endpackage

`default_nettype wire

// File: src/tpl_dac_params.svh
// lane, channel, sample and dma slot geometry macros for the jesd204 dac transport layer

`ifndef TPL_DAC_PARAMS_SVH
`define TPL_DAC_PARAMS_SVH

// ************************************************************
// link geometry (L=2, M=2, S=1, N=NP=16)
// ************************************************************

`define TPL_NUM_LANES            2
`define TPL_NUM_CHANNELS         2
`define TPL_OCTETS_PER_BEAT      4
`define TPL_BITS_PER_SAMPLE      16

// dma side, one sample per 24-bit slot
`define TPL_DMA_BITS_PER_SAMPLE  24

// samples per channel per beat
`define TPL_SAMPLES_PER_BEAT     2

`define TPL_LINK_WIDTH           64
`define TPL_DMA_WIDTH            96

`endif
